// ==== Bender.yml ====
package:
  name: conv_accel

sources:
  - verilog/conv_pkg.sv
  - verilog/conv_scratchpad.sv
  - verilog/conv_controller.sv
  - verilog/conv_engine.sv
  - verilog/conv_accel_top.sv
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/conv_accel_sva.sv
      - test/tb_conv_accel.sv

// ==== src.f ====
verilog/conv_pkg.sv
verilog/conv_scratchpad.sv
verilog/conv_controller.sv
verilog/conv_engine.sv
verilog/conv_accel_top.sv
test/tb_clk_gen.sv
test/conv_accel_sva.sv
test/tb_conv_accel.sv

// ==== test/conv_accel_sva.sv ====
`timescale 1ns/1ps

module conv_accel_sva (
    input logic clk_i,
    input logic rst_n_i,
    input logic start_i,
    input logic rst_i,
    input logic idle_i,
    input logic done_i,
    input logic wr_i
);

    int err_cnt = 0; // read by the testbench at the end of the run.

    a_start_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i) start_i |=> !start_i)
        else begin
            err_cnt++;
            $error("start strobe held for more than one cycle.");
        end

    a_rst_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i) rst_i |=> !rst_i)
        else begin
            err_cnt++;
            $error("soft reset strobe held for more than one cycle.");
        end

    a_done_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i) !(done_i && idle_i))
        else begin
            err_cnt++;
            $error("done pulse while the engine is idle.");
        end

    a_idle_write: assert property (@(posedge clk_i) disable iff (!rst_n_i) idle_i |-> !wr_i)
        else begin
            err_cnt++;
            $error("engine wrote the scratchpad while idle.");
        end

endmodule

// the engine sees the controller strobes on its inputs.
bind conv_engine conv_accel_sva u_sva (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .start_i (start_i),
    .rst_i   (soft_rst_i),
    .idle_i  (idle_o),
    .done_i  (done_o),
    .wr_i    (mem_req_o.en && mem_req_o.we)
);

// ==== test/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o; // 8 ns period.
    end

    // reset held low for the first 8 rising edges.
    initial begin
        rst_n_o = 1'b0;
        repeat (8) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

// ==== test/tb_conv_accel.sv ====
`timescale 1ns/1ps

module tb_conv_accel;

    localparam int MAX_DIM  = 12; // largest map whose three regions fit side by side.
    localparam int NUM_RUNS = 7;
    localparam int RUN_CYC  = 10 + (MAX_DIM - 2) * (MAX_DIM - 2) * 11 + 2;
    localparam int HOST_CYC = 1200; // loading and readback around one run.
    localparam int TIMEOUT_NS = (NUM_RUNS * (RUN_CYC * 2 + HOST_CYC) + 2000) * 8;
    localparam logic [conv_pkg::ADDR_W-1:0] IDLE_ADDR = 10'h0ff; // unmapped.

    logic                        clk;
    logic                        rst_n;
    logic [conv_pkg::ADDR_W-1:0] cont_addr;
    conv_pkg::word_t             cont_data;
    logic                        cont_we;
    conv_pkg::word_t             cont_rdata;
    logic                        conv_active;

    int          mem_model [conv_pkg::MEM_DEPTH]; // expected scratchpad contents.
    int          checks;
    int          errors;
    int          tests;
    int          test_base;
    logic [31:0] rd;

    tb_clk_gen u_clk (.clk_o (clk), .rst_n_o (rst_n));

    conv_accel_top u_dut (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .cont_addr_i   (cont_addr),
        .cont_data_i   (cont_data),
        .cont_we_i     (cont_we),
        .cont_data_o   (cont_rdata),
        .conv_active_o (conv_active)
    );

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t ns %s: expected %h, got %h", $time, name, exp, act);
        end
    endtask

    function automatic logic [conv_pkg::ADDR_W-1:0] window_addr(input int idx);
        return conv_pkg::MEM_BASE + (idx % conv_pkg::MEM_DEPTH);
    endfunction

    task automatic host_write(input logic [conv_pkg::ADDR_W-1:0] addr, input logic [31:0] data);
        @(posedge clk);
        cont_addr <= addr;
        cont_data <= data;
        cont_we   <= 1'b1;
        @(posedge clk);
        cont_we   <= 1'b0;
        cont_addr <= IDLE_ADDR;
    endtask

    // window reads return one cycle after the address, registers in the same cycle.
    task automatic host_read(input logic [conv_pkg::ADDR_W-1:0] addr, output logic [31:0] data);
        @(posedge clk);
        cont_addr <= addr;
        cont_we   <= 1'b0;
        if (addr >= 10'h100 && addr < 10'h200) begin
            @(posedge clk);
            cont_addr <= IDLE_ADDR;
        end
        @(negedge clk);
        data = cont_rdata;
    endtask

    task automatic load_word(input int idx);
        int v;
        v = $urandom;
        host_write(window_addr(idx), v);
        mem_model[idx % conv_pkg::MEM_DEPTH] = v;
    endtask

    // random geometry and data, then the expected output map into the model.
    task automatic load_conv();
        int dim, od, slack, gap, wt_off, ifm_off, ofm_off, acc, r, c, k;
        dim     = 3 + $urandom % (MAX_DIM - 2);
        od      = dim - 2;
        slack   = conv_pkg::MEM_DEPTH - 9 - dim * dim - od * od;
        wt_off  = $urandom % conv_pkg::MEM_DEPTH;
        gap     = $urandom % (slack + 1);
        slack   = slack - gap;
        ifm_off = (wt_off + 9 + gap) % conv_pkg::MEM_DEPTH;
        gap     = $urandom % (slack + 1);
        ofm_off = (ifm_off + dim * dim + gap) % conv_pkg::MEM_DEPTH;
        for (k = 0; k < 9; k++) load_word(wt_off + k);
        for (k = 0; k < dim * dim; k++) load_word(ifm_off + k);
        host_write(conv_pkg::CONV_WEIGHT_OFF, wt_off);
        host_write(conv_pkg::CONV_INPUT_FM, ifm_off);
        host_write(conv_pkg::CONV_OUTPUT_FM, ofm_off);
        host_write(conv_pkg::CONV_FM_DIM, dim);
        for (r = 0; r < od; r++) begin
            for (c = 0; c < od; c++) begin
                acc = 0;
                for (k = 0; k < 9; k++) begin // kernel row major, int wraps at 32 bits.
                    acc += mem_model[(ifm_off + (r + k / 3) * dim + c + k % 3) % 256]
                         * mem_model[(wt_off + k) % 256];
                end
                mem_model[(ofm_off + r * od + c) % 256] = acc;
            end
        end
    endtask

    task automatic start_and_wait();
        host_write(conv_pkg::CONV_START, 0);
        @(negedge clk);
        compare("conv_active_o", 1, conv_active);
        @(posedge clk);
        cont_addr <= conv_pkg::CONV_STATUS; // watch the done bit as the run ends.
        while (conv_active) @(negedge clk);
        compare("status", 32'h1, cont_rdata); // done set, idle clear.
    endtask

    task automatic check_memory();
        int a;
        for (a = 0; a < conv_pkg::MEM_DEPTH; a++) begin
            host_read(window_addr(a), rd);
            compare($sformatf("mem[%0d]", a), mem_model[a], rd);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s %s (%0d errors)", tests, name,
                 (errors == test_base) ? "passed" : "FAILED", errors - test_base);
        test_base = errors;
    endtask

    initial begin
        void'($urandom(32'hd335_4fc4));
        cont_addr = IDLE_ADDR;
        cont_data = '0;
        cont_we   = 1'b0;
        checks    = 0;
        errors    = 0;
        tests     = 0;
        test_base = 0;
        while (rst_n !== 1'b1) @(posedge clk);

        host_read(conv_pkg::CONV_STATUS, rd);
        compare("status", 32'h2, rd); // idle set, done clear.
        compare("conv_active_o", 0, conv_active);
        host_read(10'h007, rd);
        compare("unmapped 0x007", 0, rd);
        host_read(10'h200, rd);
        compare("unmapped 0x200", 0, rd);
        end_test("reset state");

        for (int a = 0; a < conv_pkg::MEM_DEPTH; a++) begin
            load_word(a);
            host_read(window_addr(a), rd);
            compare($sformatf("mem[%0d]", a), mem_model[a], rd);
        end
        end_test("memory window");

        repeat (4) begin
            load_conv();
            start_and_wait();
            check_memory();
        end
        end_test("random convolutions");

        load_conv();
        compare("conv_active_o", 0, conv_active);
        host_write(conv_pkg::CONV_START, 0);
        @(negedge clk);
        compare("conv_active_o", 1, conv_active);
        repeat (5 + $urandom % 10) @(posedge clk);
        start_and_wait(); // second start lands while busy.
        check_memory();
        end_test("start while active");

        load_conv();
        host_write(conv_pkg::CONV_START, 0);
        repeat (2 + $urandom % 7) @(posedge clk);
        host_write(conv_pkg::CONV_RESET, 0);
        host_read(conv_pkg::CONV_STATUS, rd);
        compare("status", 32'h2, rd);
        compare("conv_active_o", 1, conv_active); // no done, flag kept.
        start_and_wait();
        check_memory();
        end_test("soft reset");

        errors += u_dut.u_engine.u_sva.err_cnt;
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired, the convolution runs did not finish in time");
        $display("Something failed");
        $finish;
    end

endmodule

// ==== verilog/conv_accel_top.sv ====
`timescale 1ns/1ps

module conv_accel_top (
    input  logic                         clk_i,
    input  logic                         rst_n_i,

    input  logic [conv_pkg::ADDR_W-1:0]  cont_addr_i,
    input  conv_pkg::word_t              cont_data_i,
    input  logic                         cont_we_i,
    output conv_pkg::word_t              cont_data_o,
    output logic                         conv_active_o
);

    conv_pkg::conv_cfg_t cfg;
    logic                conv_start;
    logic                conv_rst;
    logic                conv_idle;
    logic                conv_done;
    conv_pkg::mem_req_t  host_req;
    conv_pkg::word_t     host_rdata;
    conv_pkg::mem_req_t  eng_req;
    conv_pkg::word_t     eng_rdata;

    conv_controller u_ctrl (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .cont_addr_i      (cont_addr_i),
        .cont_data_i      (cont_data_i),
        .cont_we_i        (cont_we_i),
        .cont_data_o      (cont_data_o),
        .conv_active_o    (conv_active_o),
        .conv_idle_i      (conv_idle),
        .conv_done_i      (conv_done),
        .conv_start_o     (conv_start),
        .conv_rst_o       (conv_rst),
        .cfg_o            (cfg),
        .host_mem_req_o   (host_req),
        .host_mem_rdata_i (host_rdata)
    );

    conv_engine u_engine (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .start_i     (conv_start),
        .soft_rst_i  (conv_rst),
        .cfg_i       (cfg),
        .idle_o      (conv_idle),
        .done_o      (conv_done),
        .mem_req_o   (eng_req),
        .mem_rdata_i (eng_rdata)
    );

    // host and engine each own one port.
    conv_scratchpad u_spad (
        .clk_i        (clk_i),
        .host_req_i   (host_req),
        .host_rdata_o (host_rdata),
        .eng_req_i    (eng_req),
        .eng_rdata_o  (eng_rdata)
    );

endmodule

// ==== verilog/conv_controller.sv ====
`timescale 1ns/1ps

module conv_controller (
    input  logic                          clk_i,
    input  logic                          rst_n_i,

    // host register port.
    input  logic [conv_pkg::ADDR_W-1:0]   cont_addr_i,
    input  conv_pkg::word_t               cont_data_i,
    input  logic                          cont_we_i,
    output conv_pkg::word_t               cont_data_o,
    output logic                          conv_active_o,

    // engine control and status.
    input  logic                          conv_idle_i,
    input  logic                          conv_done_i,
    output logic                          conv_start_o,
    output logic                          conv_rst_o,
    output conv_pkg::conv_cfg_t           cfg_o,

    // host side of the scratchpad.
    output conv_pkg::mem_req_t            host_mem_req_o,
    input  conv_pkg::word_t               host_mem_rdata_i
);

    logic [conv_pkg::ADDR_W-1:0] mem_off;
    logic                        in_mem;
    logic                        mem_rd;
    logic                        mem_rd_q;
    logic                        idle_q;
    logic                        done_q;
    logic                        active_q;
    conv_pkg::conv_cfg_t         cfg_q;
    conv_pkg::word_t             status;

    // addresses below the window wrap to large offsets.
    assign mem_off = cont_addr_i - conv_pkg::MEM_BASE;
    assign in_mem  = (mem_off < conv_pkg::MEM_DEPTH);
    assign mem_rd  = in_mem && !cont_we_i;

    assign conv_start_o = cont_we_i && (cont_addr_i == conv_pkg::CONV_START);
    assign conv_rst_o   = cont_we_i && (cont_addr_i == conv_pkg::CONV_RESET);

    always_comb begin
        host_mem_req_o.en    = in_mem;
        host_mem_req_o.we    = in_mem && cont_we_i;
        host_mem_req_o.addr  = mem_off[conv_pkg::MEM_AW-1:0];
        host_mem_req_o.wdata = cont_data_i;
    end

    // scalar settings.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cfg_q <= '0;
        end else if (cont_we_i) begin
            case (cont_addr_i)
                conv_pkg::CONV_INPUT_FM:   cfg_q.ifm_offset <= cont_data_i[conv_pkg::MEM_AW-1:0];
                conv_pkg::CONV_OUTPUT_FM:  cfg_q.ofm_offset <= cont_data_i[conv_pkg::MEM_AW-1:0];
                conv_pkg::CONV_WEIGHT_OFF: cfg_q.wt_offset  <= cont_data_i[conv_pkg::MEM_AW-1:0];
                conv_pkg::CONV_FM_DIM:     cfg_q.fm_dim     <= cont_data_i[conv_pkg::FM_DIM_W-1:0];
                default: ;
            endcase
        end
    end

    assign cfg_o = cfg_q;

    // active flag, set by an accepted start and cleared by done.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            active_q <= 1'b0;
        end else if (conv_start_o && conv_idle_i) begin
            active_q <= 1'b1;
        end else if (conv_done_i) begin
            active_q <= 1'b0;
        end
    end

    assign conv_active_o = active_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            idle_q   <= 1'b1; // engine comes out of reset idle.
            done_q   <= 1'b0;
            mem_rd_q <= 1'b0;
        end else begin
            idle_q   <= conv_idle_i;
            done_q   <= conv_done_i;
            mem_rd_q <= mem_rd;
        end
    end

    always_comb begin
        status    = '0;
        status[1] = idle_q;
        status[0] = done_q;
    end

    // scratchpad data lands one cycle after its address.
    always_comb begin
        if (mem_rd_q) begin
            cont_data_o = host_mem_rdata_i;
        end else if (cont_addr_i == conv_pkg::CONV_STATUS) begin
            cont_data_o = status;
        end else begin
            cont_data_o = '0;
        end
    end

endmodule

// ==== verilog/conv_engine.sv ====
`timescale 1ns/1ps

module conv_engine (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    input  logic                 start_i,
    input  logic                 soft_rst_i,
    input  conv_pkg::conv_cfg_t  cfg_i,

    output logic                 idle_o,
    output logic                 done_o,

    output conv_pkg::mem_req_t   mem_req_o,
    input  conv_pkg::word_t      mem_rdata_i
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_WLOAD,
        S_PIX,
        S_WB,
        S_DONE
    } state_e;

    state_e                state_q;
    logic [3:0]            tap_q;     // next tap to request, 9 means all issued.
    logic [3:0]            dat_tap_q; // tap of the word on mem_rdata_i.
    logic                  dat_vld_q;
    logic [1:0]            kx_q;
    logic [1:0]            ky_q;
    conv_pkg::dim_t        row_q;
    conv_pkg::dim_t        col_q;
    conv_pkg::dim_t        out_dim;
    logic                  issue;
    logic                  last_col;
    logic                  last_row;
    conv_pkg::maddr_t      wt_addr;
    conv_pkg::maddr_t      pix_addr;
    conv_pkg::maddr_t      out_addr;
    conv_pkg::word_t       w_q [9];
    conv_pkg::word_t       acc_q;
    conv_pkg::word_t       prod;

    assign out_dim  = cfg_i.fm_dim - conv_pkg::dim_t'(2);
    assign last_col = (col_q == out_dim - conv_pkg::dim_t'(1));
    assign last_row = (row_q == out_dim - conv_pkg::dim_t'(1));

    assign issue = ((state_q == S_WLOAD) || (state_q == S_PIX)) && (tap_q < 4'd9);

    assign wt_addr  = cfg_i.wt_offset + conv_pkg::maddr_t'(tap_q);
    assign pix_addr = cfg_i.ifm_offset
                    + (conv_pkg::maddr_t'(row_q) + conv_pkg::maddr_t'(ky_q))
                      * conv_pkg::maddr_t'(cfg_i.fm_dim)
                    + conv_pkg::maddr_t'(col_q) + conv_pkg::maddr_t'(kx_q);
    assign out_addr = cfg_i.ofm_offset
                    + conv_pkg::maddr_t'(row_q) * conv_pkg::maddr_t'(out_dim)
                    + conv_pkg::maddr_t'(col_q);

    // product wraps to 32 bits.
    assign prod = mem_rdata_i * w_q[dat_tap_q];

    always_comb begin
        mem_req_o = '0;
        case (state_q)
            S_WLOAD: begin
                mem_req_o.en   = issue;
                mem_req_o.addr = wt_addr;
            end
            S_PIX: begin
                mem_req_o.en   = issue;
                mem_req_o.addr = pix_addr;
            end
            S_WB: begin
                mem_req_o.en    = 1'b1;
                mem_req_o.we    = 1'b1;
                mem_req_o.addr  = out_addr;
                mem_req_o.wdata = acc_q;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q   <= S_IDLE;
            tap_q     <= '0;
            dat_tap_q <= '0;
            dat_vld_q <= 1'b0;
            kx_q      <= '0;
            ky_q      <= '0;
            row_q     <= '0;
            col_q     <= '0;
        end else if (soft_rst_i) begin
            state_q   <= S_IDLE;
            dat_vld_q <= 1'b0;
        end else begin
            dat_vld_q <= issue;
            dat_tap_q <= tap_q;
            case (state_q)
                S_IDLE: begin
                    if (start_i) begin
                        state_q <= S_WLOAD;
                        tap_q   <= '0;
                        row_q   <= '0;
                        col_q   <= '0;
                    end
                end
                S_WLOAD: begin
                    if (tap_q == 4'd9) begin // last weight arrives now.
                        state_q <= S_PIX;
                        tap_q   <= '0;
                        kx_q    <= '0;
                        ky_q    <= '0;
                    end else begin
                        tap_q <= tap_q + 4'd1;
                    end
                end
                S_PIX: begin
                    if (tap_q == 4'd9) begin
                        state_q <= S_WB;
                    end else begin
                        tap_q <= tap_q + 4'd1;
                        if (kx_q == 2'd2) begin
                            kx_q <= '0;
                            ky_q <= ky_q + 2'd1;
                        end else begin
                            kx_q <= kx_q + 2'd1;
                        end
                    end
                end
                S_WB: begin
                    tap_q <= '0;
                    kx_q  <= '0;
                    ky_q  <= '0;
                    if (!last_col) begin
                        col_q   <= col_q + conv_pkg::dim_t'(1);
                        state_q <= S_PIX;
                    end else if (!last_row) begin
                        col_q   <= '0;
                        row_q   <= row_q + conv_pkg::dim_t'(1);
                        state_q <= S_PIX;
                    end else begin
                        state_q <= S_DONE;
                    end
                end
                S_DONE: state_q <= S_IDLE;
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // weights and the running sum.
    always_ff @(posedge clk_i) begin
        if (state_q == S_WLOAD && dat_vld_q) begin
            w_q[dat_tap_q] <= mem_rdata_i;
        end
        if (state_q == S_PIX) begin
            if (dat_vld_q) begin
                acc_q <= acc_q + prod;
            end
        end else begin
            acc_q <= '0; // fresh sum for the next pixel.
        end
    end

    assign idle_o = (state_q == S_IDLE);
    assign done_o = (state_q == S_DONE);

endmodule

// ==== verilog/conv_pkg.sv ====
package conv_pkg;

    // host address map.
    localparam int ADDR_W = 10;

    localparam logic [ADDR_W-1:0] CONV_START      = 10'h000;
    localparam logic [ADDR_W-1:0] CONV_RESET      = 10'h001;
    localparam logic [ADDR_W-1:0] CONV_STATUS     = 10'h002;
    localparam logic [ADDR_W-1:0] CONV_INPUT_FM   = 10'h003;
    localparam logic [ADDR_W-1:0] CONV_OUTPUT_FM  = 10'h004;
    localparam logic [ADDR_W-1:0] CONV_WEIGHT_OFF = 10'h005;
    localparam logic [ADDR_W-1:0] CONV_FM_DIM     = 10'h006;

    localparam logic [ADDR_W-1:0] MEM_BASE = 10'h100; // first word of the scratchpad window.

    // scratchpad geometry.
    localparam int MEM_DEPTH = 256;
    localparam int MEM_AW    = 8;

    // feature map side length, legal values 3 to 16.
    localparam int FM_DIM_W = 5;

    typedef logic signed [31:0] word_t;
    typedef logic [MEM_AW-1:0] maddr_t;
    typedef logic [FM_DIM_W-1:0] dim_t;

    // scalar settings held by the controller.
    typedef struct packed {
        maddr_t ifm_offset;
        maddr_t ofm_offset;
        maddr_t wt_offset;
        dim_t   fm_dim;
    } conv_cfg_t;

    // one scratchpad access, read when we is low.
    typedef struct packed {
        logic   en;
        logic   we;
        maddr_t addr;
        word_t  wdata;
    } mem_req_t;

endpackage

// ==== verilog/conv_scratchpad.sv ====
`timescale 1ns/1ps

module conv_scratchpad (
    input  logic                clk_i,

    input  conv_pkg::mem_req_t  host_req_i,
    output conv_pkg::word_t     host_rdata_o,

    input  conv_pkg::mem_req_t  eng_req_i,
    output conv_pkg::word_t     eng_rdata_o
);

    conv_pkg::word_t mem_q [conv_pkg::MEM_DEPTH];

    // both ports share one process, engine write lands last on a clash.
    always_ff @(posedge clk_i) begin
        if (host_req_i.en) begin
            if (host_req_i.we) begin
                mem_q[host_req_i.addr] <= host_req_i.wdata;
            end else begin
                host_rdata_o <= mem_q[host_req_i.addr];
            end
        end
        if (eng_req_i.en) begin
            if (eng_req_i.we) begin
                mem_q[eng_req_i.addr] <= eng_req_i.wdata;
            end else begin
                eng_rdata_o <= mem_q[eng_req_i.addr];
            end
        end
    end

endmodule
